/* list.f */
+incdir+source
source/cpuPkg.sv
source/coreBus.sv
source/controller.sv
source/registerFile.sv
source/alu.sv
source/busUnit.sv
source/cpuCore.sv
testbench/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Builds the core and its testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module cpuCoreTb -o cpuCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
exit 1

/* testbench/cpuCoreTb.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module cpuCoreTb;

    import cpuPkg::*;

    localparam int NumTests = 12;
    localparam int CycleLimit = NumTests * 400;
    localparam logic [15:0] HaltWord = {HALT, 12'h000};

    logic                       clk = 1'b0;
    logic                       rstN = 1'b0;
    logic                       read;
    logic                       write;
    logic [`DATA_WIDTH-1:0]     address;
    logic [`DATA_WIDTH-1:0]     writeData;
    logic [`DATA_WIDTH-1:0]     readData = '0;
    logic                       waitRequest = 1'b0;
    logic                       readValid = 1'b0;
    logic                       halted;

    logic [15:0]                programs [NumTests][8];
    logic [15:0]                resultAddrs [NumTests];
    logic [15:0]                expectedValues [NumTests];
    logic [`DATA_WIDTH-1:0]     mem [256];
    int                         currentTest = 0;
    int                         cycleCount = 0;
    int                         mismatches = 0;
    int                         protocolErrors = 0;
    int                         otherErrors = 0;
    int                         writeCount = 0;
    int                         pendingCount = 0;
    logic [7:0]                 pendingAddr;
    bit                         seeded = 1'b0;
    logic                       stalled = 1'b0;
    logic                       lastRead;
    logic                       lastWrite;
    logic [`DATA_WIDTH-1:0]     lastAddress;
    logic [`DATA_WIDTH-1:0]     lastWriteData;

    cpuCore dut(.*);

    always #5 clk = ~clk;

    function automatic logic [15:0] regOp(opcodes op, int rd, int rs, int rt);
        return {op, 3'(rd), 3'(rs), 3'(rt), 3'b000};
    endfunction

    function automatic logic [15:0] immOp(opcodes op, int rd, int value);
        return {op, 3'(rd), 1'b0, 8'(value)};
    endfunction

    // every word outside the program carries its own address.
    function automatic logic [15:0] fillWord(int addr);
        return {8'(addr), ~8'(addr)};
    endfunction

    task automatic aluEntry(int idx, opcodes op, int a, int b, logic [15:0] expected);
        programs[idx] = '{immOp(LDI, 1, a), immOp(LDI, 2, b), regOp(op, 3, 1, 2),
                          immOp(LDI, 4, 8'h40 + idx), regOp(ST, 3, 4, 0),
                          HaltWord, HaltWord, HaltWord};
        resultAddrs[idx] = 16'(32'h40 + idx);
        expectedValues[idx] = expected;
    endtask

    // Memory model with random back-pressure and read latency.
    always @(posedge clk) begin
        if (!seeded) begin
            void'($urandom(32'h65d1_1af1));
            seeded = 1'b1;
        end
        readValid <= 1'b0;
        waitRequest <= ($urandom % 3) == 0;
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] = (i < 8) ? programs[currentTest][i] : fillWord(i);
            end
            pendingCount = 0;
            writeCount = 0;
            stalled = 1'b0;
        end else begin
            if (halted && (read || write)) begin
                protocolErrors++;
                $display("test %0d: memory access at %0t after the core halted", currentTest, $time);
            end
            if (stalled && (read != lastRead || write != lastWrite || address != lastAddress
                    || (write && writeData != lastWriteData))) begin
                protocolErrors++;
                $display("test %0d: request changed at %0t while waitRequest was high",
                         currentTest, $time);
            end
            if (pendingCount > 0) begin
                pendingCount--;
                if (pendingCount == 0) begin
                    readValid <= 1'b1;
                    readData <= mem[pendingAddr];
                end
            end
            if (read && !waitRequest) begin
                pendingCount = $urandom_range(1, 3);
                pendingAddr = address[7:0];
            end
            if (write && !waitRequest) begin
                writeCount++;
                mem[address[7:0]] = writeData;
                if (address != resultAddrs[currentTest]) begin
                    mismatches++;
                    $display("Mismatch at %0t: address expected %h, got %h",
                             $time, resultAddrs[currentTest], address);
                end
                if (writeData != expectedValues[currentTest]) begin
                    mismatches++;
                    $display("Mismatch at %0t: writeData expected %h, got %h",
                             $time, expectedValues[currentTest], writeData);
                end
            end
            stalled = (read || write) && waitRequest;
            lastRead = read;
            lastWrite = write;
            lastAddress = address;
            lastWriteData = writeData;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("test %0d: halted not reached within %0d cycles", currentTest, CycleLimit);
            $display("mismatches %0d, protocol errors %0d, other errors %0d",
                     mismatches, protocolErrors, otherErrors + 1);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        aluEntry(0, ADD, 'hC3, 'h5A, 16'(16'hC3 + 16'h5A));
        aluEntry(1, SUB, 'h5A, 'hC3, 16'(16'h5A - 16'hC3)); // wraps below zero.
        aluEntry(2, AND, 'hC3, 'h5A, 16'hC3 & 16'h5A);
        aluEntry(3, OR, 'hC3, 'h5A, 16'hC3 | 16'h5A);
        aluEntry(4, XOR, 'hC3, 'h5A, 16'hC3 ^ 16'h5A);
        aluEntry(5, SHL, 'hB5, 0, 16'(16'hB5 << 0));
        aluEntry(6, SHL, 'hB5, 1, 16'(16'hB5 << 1));
        aluEntry(7, SHL, 'hB5, 15, 16'(16'hB5 << 15));
        // r5 holds 22 if the jump is taken and 11 if it falls through.
        programs[8] = '{immOp(LDI, 1, 'h37), immOp(LDI, 4, 'h60), immOp(LDI, 5, 'h22),
                        regOp(SUB, 3, 1, 1), immOp(JMP, EQ, 6), immOp(LDI, 5, 'h11),
                        regOp(ST, 5, 4, 0), HaltWord};
        resultAddrs[8] = 16'h60;
        expectedValues[8] = (16'h37 - 16'h37 == 16'h0) ? 16'h22 : 16'h11;
        programs[9] = '{immOp(LDI, 1, 'h37), immOp(LDI, 4, 'h61), immOp(LDI, 5, 'h22),
                        regOp(SUB, 3, 1, 1), immOp(JMP, NE, 6), immOp(LDI, 5, 'h11),
                        regOp(ST, 5, 4, 0), HaltWord};
        resultAddrs[9] = 16'h61;
        expectedValues[9] = (16'h37 - 16'h37 != 16'h0) ? 16'h22 : 16'h11;
        programs[10] = '{immOp(LDI, 4, 'hF0), regOp(LD, 1, 4, 0), immOp(LDI, 5, 'h22),
                         regOp(ADD, 3, 1, 1), immOp(JMP, CS, 6), immOp(LDI, 5, 'h11),
                         regOp(ST, 5, 4, 0), HaltWord};
        resultAddrs[10] = 16'hF0;
        expectedValues[10] = ({1'b0, fillWord('hF0)} + {1'b0, fillWord('hF0)} > 17'h0FFFF)
                             ? 16'h22 : 16'h11;
        programs[11] = '{immOp(LDI, 4, 'h90), regOp(LD, 1, 4, 0), immOp(LDI, 2, 'h3C),
                         regOp(ADD, 3, 1, 2), immOp(LDI, 5, 'hA0), regOp(ST, 3, 5, 0),
                         HaltWord, HaltWord};
        resultAddrs[11] = 16'hA0;
        expectedValues[11] = 16'(fillWord('h90) + 16'h3C);

        for (int t = 0; t < NumTests; t++) begin
            @(posedge clk);
            rstN <= 1'b0;
            currentTest = t;
            repeat (3) @(posedge clk);
            if (read || write || halted) begin
                otherErrors++;
                $display("test %0d: read, write or halted is high during reset", t);
            end
            rstN <= 1'b1;
            while (!halted) @(posedge clk);
            repeat (5) @(posedge clk); // no access may follow the halt.
            if (writeCount != 1) begin
                otherErrors++;
                $display("test %0d: saw %0d memory writes instead of one", t, writeCount);
            end
        end

        $display("mismatches %0d, protocol errors %0d, other errors %0d",
                 mismatches, protocolErrors, otherErrors);
        if (mismatches + protocolErrors + otherErrors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* source/cpuCore.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module cpuCore(
    input   logic                       clk,
    input   logic                       rstN,
    output  logic                       read,
    output  logic                       write,
    output  logic [`DATA_WIDTH-1:0]     address,
    output  logic [`DATA_WIDTH-1:0]     writeData,
    input   logic [`DATA_WIDTH-1:0]     readData,
    input   logic                       waitRequest,
    input   logic                       readValid,
    output  logic                       halted
    );

    coreBus bus();

    controller
    controller(
        .clk,
        .rstN,
        .bus,
        .halted
    );

    registerFile
    registerFile(
        .clk,
        .rstN,
        .bus
    );

    alu
    alu(
        .clk,
        .rstN,
        .bus
    );

    busUnit
    busUnit(
        .clk,
        .rstN,
        .bus,
        .read,
        .write,
        .address,
        .writeData,
        .readData,
        .waitRequest,
        .readValid
    );

endmodule

/* source/busUnit.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module busUnit(
    input   logic                       clk,
    input   logic                       rstN,
    coreBus.bus                         bus,
    output  logic                       read,
    output  logic                       write,
    output  logic [`DATA_WIDTH-1:0]     address,
    output  logic [`DATA_WIDTH-1:0]     writeData,
    input   logic [`DATA_WIDTH-1:0]     readData,
    input   logic                       waitRequest,
    input   logic                       readValid
    );

    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0]     pc;
    logic [`DATA_WIDTH-1:0]     ir;
    logic [`DATA_WIDTH-1:0]     loadRegister;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `DATA_WIDTH'(`RESET_VECTOR);
            ir <= '0;
        end else begin
            if (bus.pcLoad) begin
                pc <= bus.immediate;
            end else if (bus.pcIncrement) begin
                pc <= pc + 1'b1;
            end
            if (bus.irLoad) begin
                ir <= readData;
            end
        end
    end

    // the last word returned is kept until write-back.
    always_ff @(posedge clk) begin
        if (readValid) begin
            loadRegister <= readData;
        end
    end

    assign bus.opcode      = opcodes'(ir[15:12]);
    assign bus.condition   = conditions'(ir[11:9]);
    assign bus.rd          = ir[11:9];
    assign bus.rs          = ir[8:6];
    assign bus.rt          = ir[5:3];
    assign bus.immediate   = {{(`DATA_WIDTH-8){1'b0}}, ir[7:0]};
    assign bus.loadData    = loadRegister;
    assign bus.waitRequest = waitRequest;
    assign bus.readValid   = readValid;

    assign read      = bus.memRead;
    assign write     = bus.memWrite;
    assign address   = bus.addressSelect ? bus.rsValue : pc;
    assign writeData = bus.rtValue;

endmodule

/* source/alu.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module alu(
    input   logic           clk,
    input   logic           rstN,
    coreBus.alu             bus
    );

    import cpuPkg::*;

    localparam int Msb = `DATA_WIDTH - 1;

    logic [Msb:0]               a;
    logic [Msb:0]               b;
    logic [`DATA_WIDTH:0]       sum;
    logic [`DATA_WIDTH:0]       diff;
    logic [Msb:0]               opResult;
    logic                       carry;
    logic                       overflow;
    logic [Msb:0]               result;
    logic [Msb:0]               shifted;
    logic [`SHIFT_WIDTH-1:0]    amount;
    logic [`SHIFT_WIDTH-1:0]    count;
    logic [3:0]                 flags;

    assign a       = bus.rsValue;
    assign b       = bus.rtValue;
    assign amount  = b[`SHIFT_WIDTH-1:0];
    assign shifted = {result[Msb-1:0], 1'b0};

    always_comb begin
        sum      = {1'b0, a} + {1'b0, b};
        diff     = {1'b0, a} - {1'b0, b};
        carry    = 1'b0;
        overflow = 1'b0;
        case (bus.aluOp)
            ALUADD: begin
                opResult = sum[Msb:0];
                carry    = sum[`DATA_WIDTH];
                overflow = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
            end
            ALUSUB: begin
                opResult = diff[Msb:0];
                carry    = diff[`DATA_WIDTH]; // carry means a borrow here.
                overflow = (a[Msb] != b[Msb]) && (diff[Msb] != a[Msb]);
            end
            ALUAND:  opResult = a & b;
            ALUOR:   opResult = a | b;
            ALUXOR:  opResult = a ^ b;
            default: opResult = a; // the shift starts from the unshifted operand.
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
            flags <= '0;
        end else if (bus.aluStart) begin
            count <= (bus.aluOp == ALUSHL) ? amount : '0;
            flags <= {opResult[Msb], opResult == '0, carry, overflow};
        end else if (count != '0) begin
            count <= count - 1'b1;
            flags <= {shifted[Msb], shifted == '0, result[Msb], 1'b0}; // c takes the bit out.
        end
    end

    always_ff @(posedge clk) begin
        if (bus.aluStart) begin
            result <= opResult;
        end else if (count != '0) begin
            result <= shifted;
        end
    end

    assign bus.aluDone   = bus.aluStart ? (bus.aluOp != ALUSHL || amount == '0) : (count == '0);
    assign bus.aluResult = result;
    assign bus.flags     = flags;

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

module registerFile(
    input   logic           clk,
    input   logic           rstN,
    coreBus.registers       bus
    );

    import cpuPkg::*;

    logic [`DATA_WIDTH-1:0]         regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0]         writeValue;
    logic [$clog2(`REG_COUNT)-1:0]  secondIndex;

    assign secondIndex = (bus.opcode == ST) ? bus.rd : bus.rt; // store data comes from rd.
    assign bus.rsValue = regs[bus.rs];
    assign bus.rtValue = regs[secondIndex];

    always_comb begin
        case (bus.writeSelect)
            WRITEIMMEDIATE: writeValue = bus.immediate;
            WRITELOAD:      writeValue = bus.loadData;
            default:        writeValue = bus.aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (bus.regWrite) begin
            regs[bus.rd] <= writeValue;
        end
    end

endmodule

/* source/controller.sv */
`timescale 1ns/1ps

module controller(
    input   logic               clk,
    input   logic               rstN,
    coreBus.controller          bus,
    output  logic               halted
    );

    import cpuPkg::*;

    states      state;
    states      nextState;
    logic       enable;
    logic       conditionResult;
    logic       fetchDone;
    logic       readStrobe;
    logic       writeStrobe;
    logic       startPulse;

    always_comb begin
        case (bus.condition)
            ALWAYS:  conditionResult = 1'b1;
            EQ:      conditionResult = bus.flags[2];
            NE:      conditionResult = !bus.flags[2];
            CS:      conditionResult = bus.flags[1];
            CC:      conditionResult = !bus.flags[1];
            MI:      conditionResult = bus.flags[3];
            PL:      conditionResult = !bus.flags[3];
            VS:      conditionResult = bus.flags[0];
            default: conditionResult = 1'b0;
        endcase
    end

    // a request only counts as accepted once its strobe is actually out.
    always_comb begin
        case (state)
            FETCH:     enable = readStrobe && !bus.waitRequest;
            MEMORY:    enable = (readStrobe || writeStrobe) && !bus.waitRequest;
            FETCHWAIT,
            MEMWAIT:   enable = bus.readValid;
            EXECUTE:   enable = (bus.opcode != SHL) || bus.aluDone;
            default:   enable = 1'b1;
        endcase
    end

    always_comb begin
        nextState = state;
        if (enable) begin
            case (state)
                FETCH:     nextState = FETCHWAIT;
                FETCHWAIT: nextState = DECODE;
                DECODE: begin
                    case (bus.opcode)
                        HALT:    nextState = HALTED;
                        LD, ST:  nextState = MEMORY;
                        LDI:     nextState = WRITEBACK;
                        ADD, SUB, AND, OR, XOR, SHL, JMP: begin
                            nextState = EXECUTE;
                        end
                        default: nextState = FETCH; // unused encodings do nothing.
                    endcase
                end
                EXECUTE:   nextState = (bus.opcode == JMP) ? FETCH : WRITEBACK;
                MEMORY:    nextState = (bus.opcode == LD) ? MEMWAIT : FETCH;
                MEMWAIT:   nextState = WRITEBACK;
                WRITEBACK: nextState = FETCH;
                default:   nextState = HALTED;
            endcase
        end
    end

    // Strobes and the start pulse are registered from the next state.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state       <= FETCH;
            readStrobe  <= 1'b0;
            writeStrobe <= 1'b0;
            startPulse  <= 1'b0;
        end else begin
            state       <= nextState;
            readStrobe  <= (nextState == FETCH) || (nextState == MEMORY && bus.opcode == LD);
            writeStrobe <= (nextState == MEMORY) && (bus.opcode == ST);
            startPulse  <= (state == DECODE) && (nextState == EXECUTE) && (bus.opcode != JMP);
        end
    end

    always_comb begin
        case (bus.opcode)
            SUB:     bus.aluOp = ALUSUB;
            AND:     bus.aluOp = ALUAND;
            OR:      bus.aluOp = ALUOR;
            XOR:     bus.aluOp = ALUXOR;
            SHL:     bus.aluOp = ALUSHL;
            default: bus.aluOp = ALUADD;
        endcase
        case (bus.opcode)
            LDI:     bus.writeSelect = WRITEIMMEDIATE;
            LD:      bus.writeSelect = WRITELOAD;
            default: bus.writeSelect = WRITEALU;
        endcase
    end

    assign fetchDone         = (state == FETCHWAIT) && bus.readValid;
    assign bus.irLoad        = fetchDone;
    assign bus.pcIncrement   = fetchDone;
    assign bus.pcLoad        = (state == EXECUTE) && (bus.opcode == JMP) && conditionResult;
    assign bus.addressSelect = state == MEMORY; // data accesses address through rs.
    assign bus.memRead       = readStrobe;
    assign bus.memWrite      = writeStrobe;
    assign bus.aluStart      = startPulse;
    assign bus.regWrite      = state == WRITEBACK;
    assign halted            = state == HALTED;

endmodule

/* source/coreBus.sv */
`timescale 1ns/1ps
`include "cpuParams.svh"

interface coreBus;

    import cpuPkg::*;

    logic                            irLoad, pcIncrement, pcLoad, addressSelect;
    logic                            memRead, memWrite, aluStart, regWrite;
    aluOps                           aluOp;
    writeSelects                     writeSelect;
    opcodes                          opcode;
    conditions                       condition;
    logic [$clog2(`REG_COUNT)-1:0]   rd, rs, rt;
    logic [`DATA_WIDTH-1:0]          immediate, loadData, rsValue, rtValue, aluResult;
    logic [3:0]                      flags;
    logic                            aluDone, waitRequest, readValid;

    modport controller (
        output irLoad, pcIncrement, pcLoad, addressSelect, memRead, memWrite,
        output aluStart, aluOp, regWrite, writeSelect,
        input  opcode, condition, flags, aluDone, waitRequest, readValid
    );
    modport registers (
        input  regWrite, writeSelect, opcode, rd, rs, rt, immediate, loadData, aluResult,
        output rsValue, rtValue
    );
    modport alu (input aluStart, aluOp, rsValue, rtValue, output flags, aluDone, aluResult);
    modport bus (
        input  irLoad, pcIncrement, pcLoad, addressSelect, memRead, memWrite, rsValue, rtValue,
        output opcode, condition, rd, rs, rt, immediate, loadData, waitRequest, readValid
    );

endinterface

/* source/cpuPkg.sv */
package cpuPkg;

    typedef enum logic [3:0] {
        ADD  = 4'h0,
        SUB  = 4'h1,
        AND  = 4'h2,
        OR   = 4'h3,
        XOR  = 4'h4,
        SHL  = 4'h5,
        LDI  = 4'h6,
        LD   = 4'h7,
        ST   = 4'h8,
        JMP  = 4'h9,
        HALT = 4'hA
    } opcodes;

    // Flags are ordered {N, Z, C, V} wherever they travel as a vector.
    typedef enum logic [2:0] {
        ALWAYS, EQ, NE, CS, CC, MI, PL, VS
    } conditions;

    typedef enum logic [2:0] {
        FETCH, FETCHWAIT, DECODE, EXECUTE, MEMORY, MEMWAIT, WRITEBACK, HALTED
    } states;

    typedef enum logic [2:0] {
        ALUADD, ALUSUB, ALUAND, ALUOR, ALUXOR, ALUSHL
    } aluOps;

    typedef enum logic [1:0] {
        WRITEALU, WRITEIMMEDIATE, WRITELOAD
    } writeSelects;

endpackage

/* source/cpuParams.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Word width of registers, memory data and addresses.
`define DATA_WIDTH   16

`define REG_COUNT    8

// Program counter value after reset.
`define RESET_VECTOR 0

// Only the low bits of the second operand count for SHL.
`define SHIFT_WIDTH  4

`endif
